/* hdl/mdu_defs.svh */
// Width macros for the M extension unit
// W-type handling assumes MDU_XLEN is 64
// The divider runs one step per quotient bit with no early exit

`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath width
////////////////////////////////////////////////////////////////////////////

// Integer register width
`define MDU_XLEN 64

// Restoring divider iterations, one per quotient bit
`define MDU_DIV_STEPS `MDU_XLEN

`endif

/* hdl/mduOpPkg.sv */
// Operation encodings of the M extension, taken straight from funct3
// Helpers classify an encoding as a divide and as signed

`default_nettype none

package mduOpPkg;

	// funct3 of the OP / OP-32 M instructions
	typedef enum logic [2:0] {
		mduMul    = 3'b000,
		mduMulh   = 3'b001,
		mduMulhsu = 3'b010,
		mduMulhu  = 3'b011,
		mduDiv    = 3'b100,
		mduDivu   = 3'b101,
		mduRem    = 3'b110,
		mduRemu   = 3'b111
	} mduFunct3T;

	// Upper funct3 bit marks div, divu, rem and remu
	function automatic logic isDivOp(input mduFunct3T op);
		return op[2];
	endfunction

	// Even encodings of the divide group are the signed ones
	function automatic logic isSignedDiv(input mduFunct3T op);
		return ~op[0];
	endfunction

endpackage

`default_nettype wire

/* hdl/mduDataPkg.sv */
// Data word types of the multiply/divide unit
// Widths follow MDU_XLEN from the shared defines header

`default_nettype none

`include "mdu_defs.svh"

package mduDataPkg;

	////////////////////////////////////////////////////////////////////////
	// Register and product words
	////////////////////////////////////////////////////////////////////////

	// One integer register
	typedef logic [`MDU_XLEN-1:0] xlenWordT;

	// Full double-width product, only ever sliced into halves
	typedef logic [2*`MDU_XLEN-1:0] prodWordT;

endpackage

`default_nettype wire

/* hdl/mduMultiplier.sv */
// Single-stage multiplier, Execute operands to a Memory-stage product
// The whole product is formed in one cycle; synthesis must meet timing on it
// flushM clears the product register and has priority over stallM

`timescale 1ns/1ns
`default_nettype none

`include "mdu_defs.svh"

module mduMultiplier
	import mduDataPkg::*, mduOpPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      stallM,
	input  logic      flushM,
	input  xlenWordT  srcA,
	input  xlenWordT  srcB,
	input  mduFunct3T funct3,
	output prodWordT  prodM
);

	logic                           aSigned;
	logic                           bSigned;
	logic signed [`MDU_XLEN:0]      aExt;
	logic signed [`MDU_XLEN:0]      bExt;
	logic signed [2*`MDU_XLEN+1:0]  fullProd;

	// Signedness per operand
	// mulhsu mixes a signed A with an unsigned B
	// mul takes the low half only, so its choice does not matter
	always_comb begin
		aSigned = (funct3 == mduMulh) || (funct3 == mduMulhsu);
		bSigned = (funct3 == mduMulh);
	end

	// One extra bit turns every case into a signed multiply
	always_comb begin
		aExt     = {aSigned & srcA[`MDU_XLEN-1], srcA};
		bExt     = {bSigned & srcB[`MDU_XLEN-1], srcB};
		fullProd = aExt * bExt;
	end

	////////////////////////////////////////////////////////////////////////
	// Memory-stage product register
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			prodM <= '0;
		end else if (flushM) begin
			prodM <= '0;
		end else if (!stallM) begin
			// Top two bits are only sign copies
			prodM <= fullProd[2*`MDU_XLEN-1:0];
		end
	end

endmodule

`default_nettype wire

/* hdl/mduDivider.sv */
// Iterative restoring divider, one quotient bit per cycle
// divBusy is high for MDU_DIV_STEPS+1 cycles after a start
// Results hold from the fall of divBusy until the next fix-up cycle
// A start is ignored in the done state, which waits for stallM low
// W-type operands assume MDU_XLEN is 64

`timescale 1ns/1ns
`default_nettype none

`include "mdu_defs.svh"

module mduDivider
	import mduDataPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     stallM,
	input  logic     start,
	input  logic     divSigned,
	input  logic     w64,
	input  xlenWordT srcA,
	input  xlenWordT srcB,
	output logic     divBusy,
	output xlenWordT quotM,
	output xlenWordT remM
);

	localparam int Xlen  = `MDU_XLEN;
	localparam int Steps = `MDU_DIV_STEPS;
	localparam int CntW  = $clog2(Steps + 1);

	localparam logic [1:0] StIdle = 2'd0;
	localparam logic [1:0] StBusy = 2'd1;
	localparam logic [1:0] StDone = 2'd2;

	logic [1:0]      state;
	logic [CntW-1:0] cnt;

	// Execute-side operand preparation
	xlenWordT aPrep, bPrep, aMag, bMag, mostNeg;
	logic     aNeg, bNeg, zeroE, ovfE;

	// Iteration datapath
	xlenWordT        qR, rR, dR, aHold;
	logic [Xlen:0]   trial, diff;
	xlenWordT        qNext, rNext;
	logic            negQ, negR, divZero, overflow;
	xlenWordT        qFix, rFix;

	////////////////////////////////////////////////////////////////////////
	// Operand preparation
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		// W-type works on the low word, extended by signedness
		if (w64) begin
			aPrep   = {{(Xlen-32){divSigned & srcA[31]}}, srcA[31:0]};
			bPrep   = {{(Xlen-32){divSigned & srcB[31]}}, srcB[31:0]};
			mostNeg = {{(Xlen-31){1'b1}}, {31{1'b0}}};
		end else begin
			aPrep   = srcA;
			bPrep   = srcB;
			mostNeg = {1'b1, {(Xlen-1){1'b0}}};
		end
		aNeg  = divSigned & aPrep[Xlen-1];
		bNeg  = divSigned & bPrep[Xlen-1];
		// Magnitudes for the unsigned core
		aMag  = aNeg ? -aPrep : aPrep;
		bMag  = bNeg ? -bPrep : bPrep;
		// RISC-V corner cases, caught before the run
		zeroE = (bPrep == '0);
		ovfE  = divSigned & (aPrep == mostNeg) & (&bPrep);
	end

	////////////////////////////////////////////////////////////////////////
	// One restoring step and the final fix-up
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Shift next dividend bit into the partial remainder
		trial = {rR, qR[Xlen-1]};
		diff  = trial - {1'b0, dR};
		// Borrow means restore the shifted remainder
		rNext = diff[Xlen] ? trial[Xlen-1:0] : diff[Xlen-1:0];
		qNext = {qR[Xlen-2:0], ~diff[Xlen]};
	end

	always_comb begin
		if (divZero) begin
			qFix = '1;
			rFix = aHold;
		end else if (overflow) begin
			qFix = aHold;
			rFix = '0;
		end else begin
			// Quotient sign from both operands, remainder from the dividend
			qFix = negQ ? -qR : qR;
			rFix = negR ? -rR : rR;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= StIdle;
			cnt   <= '0;
		end else begin
			case (state)
				StIdle: begin
					if (start) begin
						state <= StBusy;
						cnt   <= '0;
					end
				end
				StBusy: begin
					// Steps iterations, then one fix-up cycle
					if (cnt == CntW'(Steps)) state <= StDone;
					else cnt <= cnt + 1'b1;
				end
				StDone: begin
					// Divide still in Execute while Memory is stalled
					if (!stallM) state <= StIdle;
				end
				default: state <= StIdle;
			endcase
		end
	end

	// Datapath registers, loaded under FSM control
	always_ff @(posedge clk) begin
		if (state == StIdle && start) begin
			qR       <= aMag;
			dR       <= bMag;
			rR       <= '0;
			aHold    <= aPrep;
			negQ     <= aNeg ^ bNeg;
			negR     <= aNeg;
			divZero  <= zeroE;
			overflow <= ovfE;
		end else if (state == StBusy && cnt != CntW'(Steps)) begin
			qR <= qNext;
			rR <= rNext;
		end
	end

	// Results, read as zero until the first divide finishes
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			quotM <= '0;
			remM  <= '0;
		end else if (state == StBusy && cnt == CntW'(Steps)) begin
			quotM <= qFix;
			remM  <= rFix;
		end
	end

	assign divBusy = (state == StBusy);

endmodule

`default_nettype wire

/* hdl/mduResultSelect.sv */
// Memory-stage result mux and the Writeback register
// W-type results sign-extend bit 31, which assumes MDU_XLEN is 64
// Flushes clear their register and win over the matching stall

`timescale 1ns/1ns
`default_nettype none

`include "mdu_defs.svh"

module mduResultSelect
	import mduDataPkg::*, mduOpPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      stallM,
	input  logic      stallW,
	input  logic      flushM,
	input  logic      flushW,
	input  logic      w64,
	input  mduFunct3T funct3M,
	input  prodWordT  prodM,
	input  xlenWordT  quotM,
	input  xlenWordT  remM,
	output xlenWordT  resultW
);

	logic     w64M;
	xlenWordT prelimM;
	xlenWordT resultM;

	// W flag follows the operation into Memory
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) w64M <= 1'b0;
		else if (flushM) w64M <= 1'b0;
		else if (!stallM) w64M <= w64;
	end

	////////////////////////////////////////////////////////////////////////
	// Result choice
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (funct3M)
			mduMul:                      prelimM = prodM[`MDU_XLEN-1:0];
			mduMulh, mduMulhsu, mduMulhu: prelimM = prodM[2*`MDU_XLEN-1:`MDU_XLEN];
			mduDiv, mduDivu:             prelimM = quotM;
			default:                     prelimM = remM;
		endcase
		// W-type ops return a sign-extended low word
		resultM = w64M ? {{(`MDU_XLEN-32){prelimM[31]}}, prelimM[31:0]} : prelimM;
	end

	// Writeback register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) resultW <= '0;
		else if (flushW) resultW <= '0;
		else if (!stallW) resultW <= resultM;
	end

endmodule

`default_nettype wire

/* hdl/mdu.sv */
// M extension multiply/divide unit, Execute to Writeback
// The hazard unit is external; it must hold Execute inputs while divBusy
// Memory registers advance only when stallM and divBusy are both low
// No forwarding inside the unit, srcA and srcB are already forwarded

`timescale 1ns/1ns
`default_nettype none

module mdu
	import mduDataPkg::*, mduOpPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      mduValid,
	input  logic      w64,
	input  logic      stallM,
	input  logic      stallW,
	input  logic      flushM,
	input  logic      flushW,
	input  xlenWordT  srcA,
	input  xlenWordT  srcB,
	input  mduFunct3T funct3,
	output logic      divBusy,
	output xlenWordT  resultW
);

	logic      divStart;
	logic      divSigned;
	logic      holdM;
	mduFunct3T funct3M;
	prodWordT  prodM;
	xlenWordT  quotM;
	xlenWordT  remM;

	// Divide request and its signedness, straight from funct3
	assign divStart  = mduValid & isDivOp(funct3);
	assign divSigned = isSignedDiv(funct3);

	// A running divide keeps Execute from moving to Memory
	assign holdM = stallM | divBusy;

	// funct3 into Memory, a flushed slot reads as mul of zero
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) funct3M <= mduMul;
		else if (flushM) funct3M <= mduMul;
		else if (!holdM) funct3M <= funct3;
	end

	////////////////////////////////////////////////////////////////////////
	// Datapath blocks
	////////////////////////////////////////////////////////////////////////

	mduMultiplier mul_i (
		.clk, .rstN, .stallM(holdM), .flushM,
		.srcA, .srcB, .funct3, .prodM
	);

	mduDivider div_i (
		.clk, .rstN, .stallM(holdM), .start(divStart), .divSigned, .w64,
		.srcA, .srcB, .divBusy, .quotM, .remM
	);

	mduResultSelect sel_i (
		.clk, .rstN, .stallM(holdM), .stallW, .flushM, .flushW, .w64,
		.funct3M, .prodM, .quotM, .remM, .resultW
	);

endmodule

`default_nettype wire

/* verif/tbClockGen.sv */
// Free-running testbench clock, starts low
// Period in ns, kept even so both halves are equal

`timescale 1ns/1ns
`default_nettype none

module tbClockGen #(
	parameter int PeriodNs = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// Toggle every half period
	always begin
		#(PeriodNs / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* verif/tbMdu.sv */
// Testbench of the multiply/divide unit with a cycle model of its pipeline
// The testbench acts as the hazard unit and holds Execute while a divide runs
// One process drives, models and checks, so one seed covers all stimulus

`timescale 1ns/1ns
`default_nettype none

`include "mdu_defs.svh"

module tbMdu
	import mduDataPkg::*, mduOpPkg::*;
;

	localparam int X        = `MDU_XLEN;
	localparam int Steps    = `MDU_DIV_STEPS;
	localparam int TotalOps = 194;
	localparam longint WatchdogNs = longint'(TotalOps * (Steps + 4) + 100) * 100;

	// Model divider states
	localparam int DvIdle = 0;
	localparam int DvBusy = 1;
	localparam int DvDone = 2;

	logic clk, rstN, mduValid, w64, stallM, stallW, flushM, flushW, divBusy;
	xlenWordT srcA, srcB, resultW;
	mduFunct3T funct3;

	// Model state
	logic [2:0]     mF3;
	logic           mW64;
	logic [2*X-1:0] mProd;
	logic [X-1:0]   mQuot, mRem, pendQ, pendR, mResW;
	int             mState, mCnt;

	// Run control
	string testName;
	int    opKind, stallPct, flushPct, opsIssued, errors, checks;

	tbClockGen #(.PeriodNs(100)) clk_i (.clk);

	mdu mdu_i (
		.clk, .rstN, .mduValid, .w64, .stallM, .stallW, .flushM, .flushW,
		.srcA, .srcB, .funct3, .divBusy, .resultW
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference arithmetic
	////////////////////////////////////////////////////////////////////////////

	// Unsigned product, then remove the weight of each negative operand
	function automatic logic [2*X-1:0] mulModel(input logic [2:0] op,
			input logic [X-1:0] a, input logic [X-1:0] b);
		logic [2*X-1:0] p;
		logic           aS, bS;
		aS = (op == 3'b001) || (op == 3'b010);
		bS = (op == 3'b001);
		p  = {{X{1'b0}}, a} * {{X{1'b0}}, b};
		if (aS && a[X-1]) p = p - {b, {X{1'b0}}};
		if (bS && b[X-1]) p = p - {a, {X{1'b0}}};
		return p;
	endfunction

	// RISC-V division with its divide-by-zero and overflow results
	task automatic divModel(input logic sgn, input logic w, input logic [X-1:0] a,
			input logic [X-1:0] b, output logic [X-1:0] q, output logic [X-1:0] r);
		logic [X-1:0] ap, bp, mostNeg;
		ap      = a;
		bp      = b;
		mostNeg = {1'b1, {(X-1){1'b0}}};
		if (w) begin
			ap      = sgn ? X'($signed(a[31:0])) : X'(a[31:0]);
			bp      = sgn ? X'($signed(b[31:0])) : X'(b[31:0]);
			mostNeg = $signed(mostNeg) >>> (X - 32);
		end
		if (bp == '0) begin
			q = '1;
			r = ap;
		end else if (sgn && ap == mostNeg && bp == '1) begin
			q = ap;
			r = '0;
		end else if (sgn) begin
			// SV signed division truncates toward zero like RISC-V
			q = $signed(ap) / $signed(bp);
			r = $signed(ap) % $signed(bp);
		end else begin
			q = ap / bp;
			r = ap % bp;
		end
	endtask

	// Memory-stage result as the ISA defines it
	function automatic logic [X-1:0] selectModel(input logic [2:0] op, input logic w,
			input logic [2*X-1:0] p, input logic [X-1:0] q, input logic [X-1:0] r);
		logic [X-1:0] v;
		case (op)
			3'b000:                 v = p[X-1:0];
			3'b001, 3'b010, 3'b011: v = p[2*X-1:X];
			3'b100, 3'b101:         v = q;
			default:                v = r;
		endcase
		return w ? X'($signed(v[31:0])) : v;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Next Execute operation, shaped by the current phase
	task automatic issueOp();
		logic [2:0]   f3;
		logic [X-1:0] a, b;
		logic         w;
		w = 1'($urandom % 2);
		a = {$urandom, $urandom};
		b = {$urandom, $urandom};
		// Small divisors now and then, zero included
		if ($urandom % 4 == 0) b = X'($urandom % 16);
		case (opKind)
			0: f3 = 3'($urandom % 4);
			1: f3 = 3'(4 + $urandom % 4);
			2: begin
				if ($urandom % 2) begin
					f3 = 3'(4 + $urandom % 4);
					b  = w ? {$urandom, 32'h0} : '0;
				end else begin
					// Most negative over minus one, signed ops only
					f3 = ($urandom % 2) ? 3'b100 : 3'b110;
					a  = w ? {$urandom, 32'h8000_0000} : {1'b1, {(X-1){1'b0}}};
					b  = w ? {$urandom, 32'hffff_ffff} : '1;
				end
			end
			default: f3 = 3'($urandom % 8);
		endcase
		mduValid <= (opKind == 3) ? ($urandom % 8 != 0) : 1'b1;
		funct3   <= mduFunct3T'(f3);
		w64      <= w;
		srcA     <= a;
		srcB     <= b;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One clock edge: check, advance the model, drive
	////////////////////////////////////////////////////////////////////////////

	task automatic cycleStep();
		logic [2:0]   f3e;
		logic [X-1:0] resM;
		logic         hold, adv;
		f3e  = funct3;
		resM = selectModel(mF3, mW64, mProd, mQuot, mRem);
		// Outputs are sampled before this edge takes effect
		if (rstN) begin
			checks++;
			assert (resultW === mResW) else begin
				errors++;
				$display("Fail %s: resultW expected %h actual %h", testName, mResW, resultW);
			end
			assert (divBusy === (mState == DvBusy)) else begin
				errors++;
				$display("Fail %s: divBusy expected %b actual %b", testName,
					mState == DvBusy, divBusy);
			end
		end
		if (!rstN) begin
			mF3    = 3'b000;
			mW64   = 1'b0;
			mProd  = '0;
			mQuot  = '0;
			mRem   = '0;
			mResW  = '0;
			mState = DvIdle;
			mCnt   = 0;
		end else begin
			hold = stallM | (mState == DvBusy);
			// Divide stays in Execute until its result is ready
			adv  = !stallM && mState != DvBusy && !(mduValid && f3e[2] && mState == DvIdle);
			// Writeback register
			if (flushW) mResW = '0;
			else if (!stallW) mResW = resM;
			// Memory registers
			if (flushM) begin
				mF3   = 3'b000;
				mW64  = 1'b0;
				mProd = '0;
			end else if (!hold) begin
				mF3   = f3e;
				mW64  = w64;
				mProd = mulModel(f3e, srcA, srcB);
			end
			// Divider, busy for Steps+1 cycles
			case (mState)
				DvIdle: begin
					if (mduValid && f3e[2]) begin
						divModel(~f3e[0], w64, srcA, srcB, pendQ, pendR);
						mState = DvBusy;
						mCnt   = 0;
					end
				end
				DvBusy: begin
					if (mCnt == Steps) begin
						mQuot  = pendQ;
						mRem   = pendR;
						mState = DvDone;
					end else begin
						mCnt++;
					end
				end
				default: if (!stallM) mState = DvIdle;
			endcase
			if (adv) begin
				issueOp();
				opsIssued++;
			end
			stallM <= ($urandom % 100) < stallPct;
			stallW <= ($urandom % 100) < stallPct;
			flushM <= ($urandom % 100) < flushPct;
			flushW <= ($urandom % 100) < flushPct;
		end
	endtask

	// Run until a phase has issued its share of operations
	task automatic runPhase(input string name, input int kind, input int stP,
			input int flP, input int count);
		int target;
		testName = name;
		opKind   = kind;
		stallPct = stP;
		flushPct = flP;
		target   = opsIssued + count;
		while (opsIssued < target) begin
			@(posedge clk);
			cycleStep();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hac25e337));
		rstN      = 1'b0;
		mduValid  = 1'b0;
		w64       = 1'b0;
		stallM    = 1'b0;
		stallW    = 1'b0;
		flushM    = 1'b0;
		flushW    = 1'b0;
		srcA      = '0;
		srcB      = '0;
		funct3    = mduMul;
		pendQ     = 'x;
		pendR     = 'x;
		errors    = 0;
		checks    = 0;
		opsIssued = 0;
		opKind    = 0;
		stallPct  = 0;
		flushPct  = 0;
		testName  = "reset";
		repeat (10) begin
			@(posedge clk);
			cycleStep();
		end
		rstN <= 1'b1;
		@(negedge clk);
		assert (resultW === '0 && divBusy === 1'b0) else begin
			errors++;
			$display("Fail reset: resultW and divBusy expected 0 0 actual %h %b",
				resultW, divBusy);
		end
		runPhase("mulNoStall", 0, 0, 0, 40);
		runPhase("divRandom", 1, 0, 0, 30);
		runPhase("divCorner", 2, 0, 0, 24);
		runPhase("randomStall", 3, 25, 0, 60);
		runPhase("flush", 3, 20, 10, 40);
		// Drain the pipeline with plain multiplies
		testName = "drain";
		opKind   = 0;
		stallPct = 0;
		flushPct = 0;
		repeat (Steps + 8) begin
			@(posedge clk);
			cycleStep();
		end
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the op count and the divide length
	initial begin
		#(WatchdogNs);
		$display("Watchdog expired before all operations completed");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/mduOpPkg.sv
hdl/mduDataPkg.sv
hdl/mduMultiplier.sv
hdl/mduDivider.sv
hdl/mduResultSelect.sv
hdl/mdu.sv
verif/tbClockGen.sv
verif/tbMdu.sv

/* Makefile */
# Verilator build and run of the multiply/divide unit testbench

TOP := tbMdu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
